/* design/lsu_ctrl_fsm.sv */
/*
 * Load/store control FSM
 * sequences bus requests, splits misaligned accesses into two words,
 * tracks first-half errors and generates the response strobes
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      lsu_req_i,
  input  logic                      lsu_we_i,
  input  lsu_pkg::lsu_type_e        lsu_type_i,
  input  logic [lsu_pkg::OffW-1:0]  offset_i,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic                      data_err_i,
  output logic                      data_req_o,
  output logic                      addr_incr_req_o,    // execute side presents addr + 4
  output logic                      second_part_o,      // second word of a split access
  output logic                      ctrl_update_o,      // capture attributes in the aligner
  output logic                      rdata_update_o,     // capture first load beat
  output logic                      lsu_req_done_o,
  output logic                      lsu_resp_valid_o,
  output logic                      lsu_rdata_valid_o,
  output logic                      load_err_o,
  output logic                      store_err_o,
  output logic                      busy_o
);

  import lsu_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WAIT_GNT_MIS,           // first half of a split access not yet granted
    S_WAIT_RVALID_MIS,        // first half granted, second half requested
    S_WAIT_GNT,               // single or second request waiting for grant
    S_WAIT_RVALID_GNTS_DONE   // both granted, first response still out
  } ls_state_e;

  ls_state_e state_q, state_d;
  logic      second_part_q, second_part_d;
  logic      err_q, err_d;   // first half came back with an error
  logic      we_q;           // write flag of the outstanding access
  logic      split_access;
  logic      resp_err;

  // word at any nonzero offset, or a halfword crossing into the next word
  assign split_access = ((lsu_type_i == LSU_WORD) && (offset_i != '0)) ||
                        ((lsu_type_i == LSU_HALF) && (offset_i == {OffW{1'b1}}));

  ////////////////////////////////////////////////////////////////////////////
  // next state

  always_comb begin
    state_d         = state_q;
    second_part_d   = second_part_q;
    err_d           = err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;

    unique case (state_q)
      S_IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;   // same cycle as the request
          err_d      = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            second_part_d = split_access;
            state_d       = split_access ? S_WAIT_RVALID_MIS : S_IDLE;
          end else begin
            state_d       = split_access ? S_WAIT_GNT_MIS : S_WAIT_GNT;
          end
        end
      end

      S_WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          second_part_d = 1'b1;
          state_d       = S_WAIT_RVALID_MIS;
        end
      end

      S_WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1;   // second half goes out right away
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~we_q;
          second_part_d  = ~data_gnt_i;   // still needed if not granted yet
          state_d        = data_gnt_i ? S_IDLE : S_WAIT_GNT;
        end else if (data_gnt_i) begin
          second_part_d = 1'b0;
          state_d       = S_WAIT_RVALID_GNTS_DONE;
        end
      end

      S_WAIT_GNT: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = second_part_q;   // only when this is the second half
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          second_part_d = 1'b0;
          state_d       = S_IDLE;
        end
      end

      S_WAIT_RVALID_GNTS_DONE: begin
        addr_incr_req_o = 1'b1;   // keep addr + 4 until the first beat returns
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~we_q;
          state_d        = S_IDLE;
        end
      end

      default: state_d = S_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= S_IDLE;
      second_part_q <= 1'b0;
      err_q         <= 1'b0;
    end else begin
      state_q       <= state_d;
      second_part_q <= second_part_d;
      err_q         <= err_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else if (ctrl_update_o) begin
      we_q <= lsu_we_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response strobes

  // the last grant of an access sends the FSM back to idle
  assign lsu_req_done_o    = (lsu_req_i | (state_q != S_IDLE)) & (state_d == S_IDLE);
  assign lsu_resp_valid_o  = data_rvalid_i & (state_q == S_IDLE);  // final beat only
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~we_q;

  assign resp_err    = err_q | data_err_i;   // either half failed
  assign load_err_o  = resp_err & ~we_q & lsu_resp_valid_o;
  assign store_err_o = resp_err &  we_q & lsu_resp_valid_o;

  assign second_part_o = second_part_q;
  assign busy_o        = (state_q != S_IDLE);

endmodule

`default_nettype wire

/* design/lsu_load_align.sv */
/*
 * Load aligner
 * holds the first beat of a split load and the access attributes,
 * rebuilds the loaded value and zero- or sign-extends it
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       ctrl_update_i,   // capture access attributes
  input  logic                       rdata_update_i,  // capture first beat
  input  lsu_pkg::lsu_type_e         lsu_type_i,
  input  logic [lsu_pkg::OffW-1:0]   offset_i,
  input  logic                       sign_ext_i,
  input  logic [lsu_pkg::DataW-1:0]  bus_rdata_i,     // current response beat
  output logic [lsu_pkg::DataW-1:0]  rdata_o          // extended load result
);

  import lsu_pkg::*;

  logic [OffW-1:0]      offset_q;    // offset of the outstanding access
  lsu_type_e            type_q;
  logic                 sign_ext_q;
  logic [DataW-1:ByteW] rdata_q;     // upper three bytes of the first beat

  logic [DataW-1:0]     rdata_w;     // word rebuilt across both beats
  logic [DataW-1:0]     rdata_sh;    // current beat moved down to lane 0
  logic [2*ByteW-1:0]   rdata_h;     // selected halfword
  logic [ByteW-1:0]     rdata_b;     // selected byte

  ////////////////////////////////////////////////////////////////////////////
  // attribute and first beat registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      type_q     <= LSU_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= offset_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= sign_ext_i;
    end
  end

  // the lowest byte is never part of a split result
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= bus_rdata_i[DataW-1:ByteW];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // realignment

  // misaligned word: upper bytes of beat one below, low bytes of beat two above
  always_comb begin
    unique case (offset_q)
      2'b00:   rdata_w = bus_rdata_i;
      2'b01:   rdata_w = {bus_rdata_i[ByteW-1:0],   rdata_q[DataW-1:ByteW]};
      2'b10:   rdata_w = {bus_rdata_i[2*ByteW-1:0], rdata_q[DataW-1:2*ByteW]};
      2'b11:   rdata_w = {bus_rdata_i[3*ByteW-1:0], rdata_q[DataW-1:3*ByteW]};
      default: rdata_w = bus_rdata_i;
    endcase
  end

  assign rdata_sh = bus_rdata_i >> (offset_q * ByteW);  // single beat lane select

  // halfword at offset 3 straddles the word boundary, the rest fit one beat
  assign rdata_h = (offset_q == {OffW{1'b1}}) ? rdata_w[2*ByteW-1:0] : rdata_sh[2*ByteW-1:0];
  assign rdata_b = rdata_sh[ByteW-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // extension

  always_comb begin
    unique case (type_q)
      LSU_WORD: rdata_o = rdata_w;
      LSU_HALF: rdata_o = {{(DataW-2*ByteW){sign_ext_q & rdata_h[2*ByteW-1]}}, rdata_h};
      default:  rdata_o = {{(DataW-ByteW){sign_ext_q & rdata_b[ByteW-1]}}, rdata_b};
    endcase
  end

endmodule

`default_nettype wire

/* design/lsu_pkg.sv */
/*
 * Load/store unit shared definitions
 * data and address widths, byte lane geometry and the access-type encoding
 */
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  localparam int unsigned DataW = 32;         // data and address width
  localparam int unsigned BeW   = DataW / 8;  // bytes per word
  localparam int unsigned OffW  = 2;          // byte offset inside a word
  localparam int unsigned ByteW = 8;          // one byte lane

  ////////////////////////////////////////////////////////////////////////////
  // lane constants

  // enables of an access at offset 0, shifted up by the byte offset
  localparam logic [BeW-1:0] BeWord = 4'b1111;
  localparam logic [BeW-1:0] BeHalf = 4'b0011;
  localparam logic [BeW-1:0] BeByte = 4'b0001;

  // access type from the decoder, both 10 and 11 select a byte
  typedef enum logic [1:0] {
    LSU_WORD     = 2'b00,
    LSU_HALF     = 2'b01,
    LSU_BYTE     = 2'b10,
    LSU_BYTE_ALT = 2'b11
  } lsu_type_e;

endpackage

`default_nettype wire

/* design/lsu_store_align.sv */
/*
 * Store aligner
 * byte enables from access type and offset, store data rotated into lanes
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align (
  input  lsu_pkg::lsu_type_e         lsu_type_i,     // word, half or byte
  input  logic [lsu_pkg::OffW-1:0]   offset_i,       // byte offset of the access
  input  logic                       second_part_i,  // second word of a split access
  input  logic [lsu_pkg::DataW-1:0]  wdata_i,        // store data, lsb aligned
  output logic [lsu_pkg::BeW-1:0]    be_o,           // byte enables to the bus
  output logic [lsu_pkg::DataW-1:0]  wdata_o         // store data in bus lanes
);

  import lsu_pkg::*;

  logic [BeW-1:0]   be_base;  // enables at offset 0
  logic [2*BeW-1:0] be_span;  // enables over two adjacent words

  ////////////////////////////////////////////////////////////////////////////
  // byte enables

  always_comb begin
    unique case (lsu_type_i)
      LSU_WORD:     be_base = BeWord;
      LSU_HALF:     be_base = BeHalf;
      LSU_BYTE,
      LSU_BYTE_ALT: be_base = BeByte;
      default:      be_base = BeWord;
    endcase
  end

  // lower word holds the first part, anything that spills over is the second part
  assign be_span = {{BeW{1'b0}}, be_base} << offset_i;
  assign be_o    = second_part_i ? be_span[2*BeW-1:BeW] : be_span[BeW-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // store data rotation

  // rotate left by the offset, low bytes wrap into the second word's lanes
  always_comb begin
    unique case (offset_i)
      2'b00:   wdata_o = wdata_i;
      2'b01:   wdata_o = {wdata_i[DataW-ByteW-1:0],   wdata_i[DataW-1:DataW-ByteW]};
      2'b10:   wdata_o = {wdata_i[DataW-2*ByteW-1:0], wdata_i[DataW-1:DataW-2*ByteW]};
      2'b11:   wdata_o = {wdata_i[DataW-3*ByteW-1:0], wdata_i[DataW-1:DataW-3*ByteW]};
      default: wdata_o = wdata_i;
    endcase
  end

endmodule

`default_nettype wire

/* design/lsu_top.sv */
/*
 * Load/store unit top level
 * control FSM, store aligner and load aligner between execute stage and bus
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // data bus
  output logic                       data_req_o,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  logic                       data_err_i,
  output logic [lsu_pkg::DataW-1:0]  data_addr_o,    // word aligned
  output logic                       data_we_o,
  output logic [lsu_pkg::BeW-1:0]    data_be_o,
  output logic [lsu_pkg::DataW-1:0]  data_wdata_o,
  input  logic [lsu_pkg::DataW-1:0]  data_rdata_i,
  // execute stage
  input  logic                       lsu_req_i,
  input  logic                       lsu_we_i,
  input  lsu_pkg::lsu_type_e         lsu_type_i,
  input  logic                       lsu_sign_ext_i,
  input  logic [lsu_pkg::DataW-1:0]  lsu_wdata_i,
  input  logic [lsu_pkg::DataW-1:0]  lsu_addr_i,     // addr + 4 while addr_incr_req_o
  output logic [lsu_pkg::DataW-1:0]  lsu_rdata_o,
  output logic                       lsu_rdata_valid_o,
  output logic                       addr_incr_req_o,
  output logic                       lsu_req_done_o,
  output logic                       lsu_resp_valid_o,
  output logic                       load_err_o,
  output logic                       store_err_o,
  output logic                       busy_o
);

  import lsu_pkg::*;

  logic [OffW-1:0] offset;        // byte offset, same for both halves
  logic            second_part;
  logic            ctrl_update;
  logic            rdata_update;

  assign offset      = lsu_addr_i[OffW-1:0];
  assign data_addr_o = {lsu_addr_i[DataW-1:OffW], {OffW{1'b0}}};
  assign data_we_o   = lsu_we_i;

  lsu_ctrl_fsm u_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_type_i        (lsu_type_i),
    .offset_i          (offset),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_err_i        (data_err_i),
    .data_req_o        (data_req_o),
    .addr_incr_req_o   (addr_incr_req_o),
    .second_part_o     (second_part),
    .ctrl_update_o     (ctrl_update),
    .rdata_update_o    (rdata_update),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o)
  );

  lsu_store_align u_store_align (
    .lsu_type_i    (lsu_type_i),
    .offset_i      (offset),
    .second_part_i (second_part),
    .wdata_i       (lsu_wdata_i),
    .be_o          (data_be_o),
    .wdata_o       (data_wdata_o)
  );

  lsu_load_align u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .lsu_type_i     (lsu_type_i),
    .offset_i       (offset),
    .sign_ext_i     (lsu_sign_ext_i),
    .bus_rdata_i    (data_rdata_i),
    .rdata_o        (lsu_rdata_o)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the load/store unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module tb_lsu -f sim.f -o tb_lsu

# the log decides the result, not the simulator's exit status
./obj_dir/tb_lsu > sim.log 2>&1 || true
cat sim.log
grep -qx "TEST PASS" sim.log

/* sim.f */
design/lsu_pkg.sv
design/lsu_store_align.sv
design/lsu_load_align.sv
design/lsu_ctrl_fsm.sv
design/lsu_top.sv
sim/tb_lsu.sv

/* sim/tb_lsu.sv */
/*
 * Load/store unit testbench
 * table-driven accesses against a byte memory model with random grant
 * and response delays, results checked against a shadow byte array
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

  import lsu_pkg::*;

  localparam int NumEntries    = 27;
  localparam int MemBytes      = 256;                      // 64 words
  localparam int TimeoutCycles = NumEntries * 40 + 100;
  localparam logic [31:0] Seed = 32'd56;

  typedef struct packed {
    logic        we;
    lsu_type_e   typ;
    logic        sext;      // sign extend a load
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [1:0]  err_beat;  // 0 none, 1 first beat, 2 second beat
  } entry_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic data_req_o, data_gnt_i, data_rvalid_i, data_err_i, data_we_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;
  logic [3:0]  data_be_o;
  logic        lsu_req_i, lsu_we_i, lsu_sign_ext_i;
  lsu_type_e   lsu_type_i;
  logic [31:0] lsu_wdata_i, lsu_addr_i, lsu_rdata_o;
  logic        lsu_rdata_valid_o, addr_incr_req_o, lsu_req_done_o, lsu_resp_valid_o;
  logic        load_err_o, store_err_o, busy_o;

  entry_t      tbl [NumEntries];
  logic [7:0]  mem [MemBytes];      // memory behind the bus
  logic [7:0]  ref_mem [MemBytes];  // shadow copy, updated from the table only
  logic [31:0] lcg_state;
  int          cycle_cnt = 0;
  int          gnt_wait;            // cycles until the next grant
  int          rv_due[$];           // in-order response queue
  logic [31:0] rv_data[$];
  logic        rv_err[$];
  int          last_due;

  // state of the access in flight
  entry_t      cur;
  logic [3:0]  exp_be0, exp_be1;
  logic [31:0] exp_rdata;
  int          exp_beats, beats, rv_seen, done_cnt, resp_cnt;

  always #10 clk_i = ~clk_i;

  lsu_top DUT (
    .clk_i, .rst_ni,
    .data_req_o, .data_gnt_i, .data_rvalid_i, .data_err_i, .data_addr_o,
    .data_we_o, .data_be_o, .data_wdata_o, .data_rdata_i,
    .lsu_req_i, .lsu_we_i, .lsu_type_i, .lsu_sign_ext_i, .lsu_wdata_i, .lsu_addr_i,
    .lsu_rdata_o, .lsu_rdata_valid_o, .addr_incr_req_o, .lsu_req_done_o,
    .lsu_resp_valid_o, .load_err_o, .store_err_o, .busy_o
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {17'b0, lcg_state[30:16]};  // upper bits have the longer period
  endfunction

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a * 59 + 145);  // odd multiplier, every byte address differs
  endfunction

  function automatic int access_bytes(input lsu_type_e typ);
    case (typ)
      LSU_WORD: return 4;
      LSU_HALF: return 2;
      default:  return 1;
    endcase
  endfunction

  // little endian gather from the shadow copy, then extension
  function automatic logic [31:0] expected_load(input logic [31:0] addr, input lsu_type_e typ,
                                                input logic sext);
    logic [31:0] val;
    int          n;
    n   = access_bytes(typ);
    val = '0;
    for (int k = 0; k < n; k++) val[8*k +: 8] = ref_mem[8'(addr + 32'(k))];
    if (sext && n == 2 && val[15]) val[31:16] = '1;
    if (sext && n == 1 && val[7])  val[31:8]  = '1;
    return val;
  endfunction

  task automatic load_table();
    // we, type, sext, address, store data, error beat
    tbl[0]  = '{1'b1, LSU_WORD, 1'b0, 32'h10, 32'h8badf00d, 2'd0};  // aligned stores
    tbl[1]  = '{1'b1, LSU_HALF, 1'b0, 32'h16, 32'h0000c3a5, 2'd0};
    tbl[2]  = '{1'b1, LSU_BYTE, 1'b0, 32'h19, 32'h000000f7, 2'd0};
    tbl[3]  = '{1'b0, LSU_WORD, 1'b0, 32'h10, 32'h0, 2'd0};
    tbl[4]  = '{1'b0, LSU_HALF, 1'b1, 32'h16, 32'h0, 2'd0};
    tbl[5]  = '{1'b0, LSU_BYTE_ALT, 1'b1, 32'h19, 32'h0, 2'd0};
    tbl[6]  = '{1'b1, LSU_WORD, 1'b0, 32'h20, 32'h80f17fe3, 2'd0};  // lanes with top bits set
    tbl[7]  = '{1'b0, LSU_BYTE, 1'b1, 32'h20, 32'h0, 2'd0};
    tbl[8]  = '{1'b0, LSU_BYTE, 1'b1, 32'h21, 32'h0, 2'd0};
    tbl[9]  = '{1'b0, LSU_BYTE, 1'b0, 32'h22, 32'h0, 2'd0};
    tbl[10] = '{1'b0, LSU_BYTE, 1'b1, 32'h23, 32'h0, 2'd0};
    tbl[11] = '{1'b0, LSU_HALF, 1'b1, 32'h21, 32'h0, 2'd0};
    tbl[12] = '{1'b0, LSU_HALF, 1'b0, 32'h22, 32'h0, 2'd0};
    tbl[13] = '{1'b0, LSU_HALF, 1'b1, 32'h22, 32'h0, 2'd0};
    tbl[14] = '{1'b1, LSU_WORD, 1'b0, 32'h31, 32'hdeadbeef, 2'd0};  // split accesses
    tbl[15] = '{1'b0, LSU_WORD, 1'b0, 32'h31, 32'h0, 2'd0};
    tbl[16] = '{1'b1, LSU_WORD, 1'b0, 32'h42, 32'h12f45678, 2'd0};
    tbl[17] = '{1'b0, LSU_WORD, 1'b0, 32'h43, 32'h0, 2'd0};
    tbl[18] = '{1'b1, LSU_HALF, 1'b0, 32'h47, 32'h0000a55a, 2'd0};
    tbl[19] = '{1'b0, LSU_HALF, 1'b1, 32'h47, 32'h0, 2'd0};
    tbl[20] = '{1'b0, LSU_WORD, 1'b0, 32'h3e, 32'h0, 2'd0};
    tbl[21] = '{1'b0, LSU_WORD, 1'b0, 32'h51, 32'h0, 2'd2};        // bus errors
    tbl[22] = '{1'b1, LSU_HALF, 1'b0, 32'h5b, 32'h0000e001, 2'd1};
    tbl[23] = '{1'b1, LSU_WORD, 1'b0, 32'h60, 32'hfeedc0de, 2'd1};
    tbl[24] = '{1'b0, LSU_HALF, 1'b1, 32'h63, 32'h0, 2'd1};
    tbl[25] = '{1'b1, LSU_WORD, 1'b0, 32'h6b, 32'h5ac3e1b7, 2'd0};  // store at offset 3
    tbl[26] = '{1'b0, LSU_HALF, 1'b1, 32'h10, 32'h0, 2'd0};        // half at offset 0
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus model and per-cycle sampling

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > TimeoutCycles) abort_run("timeout: an access never completed");
  end

  // drive the memory side shortly after the edge
  task automatic next_edge();
    @(posedge clk_i);
    #1;
    data_gnt_i = (gnt_wait == 0);
    if (rv_due.size() != 0 && rv_due[0] <= cycle_cnt) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = rv_data.pop_front();
      data_err_i    = rv_err.pop_front();
      void'(rv_due.pop_front());
    end else begin
      data_rvalid_i = 1'b0;
      data_rdata_i  = '0;
      data_err_i    = 1'b0;
    end
  endtask

  task automatic accept_beat();
    logic [7:0]  wa;
    logic [31:0] word;
    int          due;
    wa = {cur.addr[7:2], 2'b00} + 8'(4 * beats);
    if (beats >= exp_beats) abort_run("more bus requests than the access needs");
    check("data_addr_o", {cur.addr[31:2], 2'b00} + 32'(4 * beats), data_addr_o);
    check("data_be_o", 32'((beats == 0) ? exp_be0 : exp_be1), 32'(data_be_o));
    check("data_we_o", 32'(cur.we), 32'(data_we_o));
    if (beats == 1) check("addr_incr_req_o", 32'd1, 32'(addr_incr_req_o));
    // write lands even when the response carries an error
    for (int k = 0; k < 4; k++) begin
      if (data_we_o && data_be_o[k]) mem[wa + 8'(k)] = data_wdata_o[8*k +: 8];
    end
    word = {mem[wa + 8'd3], mem[wa + 8'd2], mem[wa + 8'd1], mem[wa]};
    due  = cycle_cnt + 1 + int'(lcg_next() % 2);  // rvalid 1 to 2 cycles later
    if (due <= last_due) due = last_due + 1;      // keep responses in order
    last_due = due;
    rv_due.push_back(due);
    rv_data.push_back(cur.we ? 32'h0 : word);
    rv_err.push_back(cur.err_beat == 2'(beats + 1));
    beats    = beats + 1;
    gnt_wait = int'(lcg_next() % 4);
  endtask

  task automatic sample_cycle();
    @(negedge clk_i);  // all inputs settled a long time ago
    if (exp_beats == 1 && addr_incr_req_o) begin
      abort_run("addr_incr_req_o raised on an aligned access");
    end
    if (data_rvalid_i) rv_seen = rv_seen + 1;
    if (data_req_o) begin
      if (data_gnt_i) accept_beat();
      else if (gnt_wait != 0) gnt_wait = gnt_wait - 1;
    end
    if (lsu_req_done_o) begin
      done_cnt = done_cnt + 1;
      if (done_cnt > 1) abort_run("lsu_req_done_o pulsed twice for one request");
      check("grants at lsu_req_done_o", 32'(exp_beats), 32'(beats));
    end
    if (lsu_resp_valid_o) begin
      resp_cnt = resp_cnt + 1;
      check("rvalids at lsu_resp_valid_o", 32'(exp_beats), 32'(rv_seen));
      check("lsu_req_done_o count", 32'd1, 32'(done_cnt));
      check("load_err_o", 32'((cur.err_beat != 2'd0) && !cur.we), 32'(load_err_o));
      check("store_err_o", 32'((cur.err_beat != 2'd0) && cur.we), 32'(store_err_o));
      check("lsu_rdata_valid_o", 32'(!cur.we), 32'(lsu_rdata_valid_o));
      if (!cur.we) check("lsu_rdata_o", exp_rdata, lsu_rdata_o);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one table entry from request to response

  task automatic run_access(input int idx);
    logic [7:0] span;
    logic [7:0] ba;
    int         n;
    cur  = tbl[idx];
    n    = access_bytes(cur.typ);
    span = 8'((32'd1 << n) - 32'd1);
    span = span << cur.addr[1:0];  // upper nibble spills into the next word
    exp_be0   = span[3:0];
    exp_be1   = span[7:4];
    exp_beats = (span[7:4] != 4'd0) ? 2 : 1;
    beats     = 0;
    rv_seen   = 0;
    done_cnt  = 0;
    resp_cnt  = 0;
    if (cur.we) begin
      for (int k = 0; k < n; k++) ref_mem[8'(cur.addr + 32'(k))] = cur.wdata[8*k +: 8];
    end else begin
      exp_rdata = expected_load(cur.addr, cur.typ, cur.sext);
    end
    next_edge();
    lsu_req_i      = 1'b1;
    lsu_we_i       = cur.we;
    lsu_type_i     = cur.typ;
    lsu_sign_ext_i = cur.sext;
    lsu_wdata_i    = cur.wdata;
    lsu_addr_i     = cur.addr;
    sample_cycle();
    while (resp_cnt == 0) begin
      next_edge();
      if (done_cnt != 0) lsu_req_i = 1'b0;
      lsu_addr_i = addr_incr_req_o ? cur.addr + 32'd4 : cur.addr;  // address generator
      sample_cycle();
    end
    if (cur.we) begin
      for (int k = 0; k < n; k++) begin
        ba = 8'(cur.addr + 32'(k));
        check($sformatf("mem[0x%02h]", ba), 32'(ref_mem[ba]), 32'(mem[ba]));
      end
    end
  endtask

  initial begin
    rst_ni         = 1'b0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_err_i     = 1'b0;
    data_rdata_i   = '0;
    lsu_req_i      = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_type_i     = LSU_WORD;
    lsu_sign_ext_i = 1'b0;
    lsu_wdata_i    = '0;
    lsu_addr_i     = '0;
    for (int a = 0; a < MemBytes; a++) begin
      mem[a]     = fill_byte(a);
      ref_mem[a] = fill_byte(a);
    end
    load_table();
    lcg_state = Seed;
    last_due  = 0;
    gnt_wait  = int'(lcg_next() % 4);
    exp_beats = 1;
    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // quiet after reset
    next_edge();
    @(negedge clk_i);
    check("data_req_o", 32'd0, 32'(data_req_o));
    check("busy_o", 32'd0, 32'(busy_o));
    check("addr_incr_req_o", 32'd0, 32'(addr_incr_req_o));
    check("lsu_resp_valid_o", 32'd0, 32'(lsu_resp_valid_o));
    check("lsu_req_done_o", 32'd0, 32'(lsu_req_done_o));
    check("load_err_o", 32'd0, 32'(load_err_o));
    check("store_err_o", 32'd0, 32'(store_err_o));

    for (int i = 0; i < NumEntries; i++) run_access(i);
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
